// File: src.f
rtl/glm_fixed_pkg.sv
rtl/glm_regs_pkg.sv
rtl/update_config.sv
rtl/line_fifo.sv
rtl/model_ram.sv
rtl/scalar_vector_mult.sv
rtl/glm_update.sv
rtl/glm_update_top.sv
dv/glm_update_checker.sv
dv/glm_update_tb.sv

// File: dv/glm_update_tests.txt
# Header: offset length iterations forward slow expect_error (decimal), then hex lines lane0..lane3
# Then: initial model lines, one gradient per iteration, samples, final model, forward lines
3 2 1 0 0 0
0100 0200 0300 0400
1000 2000 0000 ff00
0080
0200 0400 0600 0800
0100 0100 0100 0100
0000 0000 0000 0000
0f80 1f80 ff80 fe80
10 2 2 1 0 0
0100 0100 0100 0100
0000 0000 0000 0000
0100 ff00
0010 0020 0030 0040
0001 0002 0003 0004
0010 0010 0010 0010
0100 ff00 0000 0200
0100 00f0 00e0 00d0
00ff fefe fffd 01fc
00f0 00e0 00d0 00c0
ffff fffe fffd fffc
0100 00f0 00e0 00d0
00ff fefe fffd 01fc
60 2 1 1 0 0
0000 0000 0000 0000
0100 0100 0100 0100
1000
1234 8000 ffff 0800
f000 0fff 7fff 0001
dcc0 0000 0010 8000
0100 0110 0110 00f0
dcc0 0000 0010 8000
0100 0110 0110 00f0
0 1 1 0 0 0
0000 0000 0000 0000
ffff
0001 ffff 0100 8000
0001 0000 0001 ff80
62 4 1 0 0 1
5 0 1 0 0 1
10 2 2 1 1 0
0100 0100 0100 0100
0000 0000 0000 0000
0100 ff00
0010 0020 0030 0040
0001 0002 0003 0004
0010 0010 0010 0010
0100 ff00 0000 0200
0100 00f0 00e0 00d0
00ff fefe fffd 01fc
00f0 00e0 00d0 00c0
ffff fffe fffd fffc
0100 00f0 00e0 00d0
00ff fefe fffd 01fc

// File: dv/glm_update_tb.sv
`timescale 1ns/1ps
`default_nettype none

module glm_update_tb;

    logic                       clk;
    logic                       reset;
    logic                       op_start;
    glm_regs_pkg::update_regs_t regs;
    logic                       sample_we;
    glm_fixed_pkg::line_t       sample_wdata;
    logic                       gradient_we;
    glm_fixed_pkg::scalar_t     gradient_wdata;
    logic                       host_we;
    glm_regs_pkg::addr_t        host_waddr;
    glm_fixed_pkg::line_t       host_wdata;
    glm_regs_pkg::addr_t        host_raddr;
    glm_fixed_pkg::line_t       host_rdata;
    logic                       forward_re;
    logic                       op_done;
    logic                       op_error;
    logic                       busy;
    logic                       sample_full;
    logic                       gradient_full;
    logic                       forward_empty;
    glm_fixed_pkg::line_t       forward_rdata;

    int                     fd;
    int                     value_errors;
    int                     other_errors;
    int                     done_pulses;
    int                     offset;
    int                     length;
    int                     iters;
    int                     fwd;
    int                     slow;
    int                     exp_err;
    glm_fixed_pkg::line_t   shadow [glm_regs_pkg::model_depth];
    glm_fixed_pkg::line_t   init_lines [$];
    glm_fixed_pkg::line_t   sample_lines [$];
    glm_fixed_pkg::line_t   exp_lines [$];
    glm_fixed_pkg::line_t   fwd_lines [$];
    glm_fixed_pkg::scalar_t grads [$];

    glm_update_top dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Pulses are stable at the falling edge.
    always @(negedge clk)
    begin
        if (!reset && op_done)
            done_pulses++;
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic check_line(input string name, input glm_fixed_pkg::line_t got,
                              input glm_fixed_pkg::line_t exp);
        if (got !== exp)
        begin
            value_errors++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            value_errors++;
            $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic read_line(output glm_fixed_pkg::line_t l);
        logic [15:0] v0;
        logic [15:0] v1;
        logic [15:0] v2;
        logic [15:0] v3;
        int          n;
        n = $fscanf(fd, "%h %h %h %h", v0, v1, v2, v3);
        if (n != 4)
        begin
            other_errors++;
            $display("Tests file ended in the middle of a test.");
        end
        l = {v3, v2, v1, v0};
    endtask

    task automatic write_model(input int a, input glm_fixed_pkg::line_t l);
        host_we    = 1'b1;
        host_waddr = glm_regs_pkg::addr_t'(a);
        host_wdata = l;
        next_cycle();
        host_we    = 1'b0;
        shadow[a]  = l;
    endtask

    task automatic verify_model();
        for (int a = 0; a < glm_regs_pkg::model_depth; a++)
        begin
            host_raddr = glm_regs_pkg::addr_t'(a);
            next_cycle();
            check_line($sformatf("model[%0d]", a), host_rdata, shadow[a]);
        end
    endtask

    task automatic push_sample(input glm_fixed_pkg::line_t l);
        check_flag("sample_full", sample_full, 1'b0);
        sample_we    = 1'b1;
        sample_wdata = l;
        next_cycle();
        sample_we    = 1'b0;
    endtask

    task automatic load_test();
        glm_fixed_pkg::line_t   l;
        logic [15:0]            g;
        int                     n;
        init_lines   = {};
        sample_lines = {};
        exp_lines    = {};
        fwd_lines    = {};
        grads        = {};
        if (exp_err == 0)
        begin
            for (int i = 0; i < length; i++)
            begin
                read_line(l);
                init_lines.push_back(l);
            end
            for (int i = 0; i < iters; i++)
            begin
                n = $fscanf(fd, "%h", g);
                if (n != 1)
                begin
                    other_errors++;
                    $display("Tests file is missing a gradient.");
                end
                grads.push_back(g);
            end
            for (int i = 0; i < length * iters; i++)
            begin
                read_line(l);
                sample_lines.push_back(l);
            end
            for (int i = 0; i < length; i++)
            begin
                read_line(l);
                exp_lines.push_back(l);
            end
            for (int i = 0; i < length * iters * fwd; i++)
            begin
                read_line(l);
                fwd_lines.push_back(l);
            end
        end
    endtask

    task automatic run_test();
        int                   start_pulses;
        int                   guard;
        int                   cnt;
        glm_fixed_pkg::line_t got;
        load_test();
        foreach (init_lines[i])
            write_model(offset + i, init_lines[i]);
        foreach (grads[i])
        begin
            check_flag("gradient_full", gradient_full, 1'b0);
            gradient_we    = 1'b1;
            gradient_wdata = grads[i];
            next_cycle();
            gradient_we    = 1'b0;
        end
        if (slow == 0)
        begin
            foreach (sample_lines[i])
                push_sample(sample_lines[i]);
        end
        start_pulses = done_pulses;
        op_start = 1'b1;
        regs.model_offset   = glm_regs_pkg::addr_t'(offset);
        regs.model_length   = 16'(length);
        regs.num_iterations = 16'(iters);
        regs.forward_enable = 1'(fwd);
        next_cycle();
        op_start = 1'b0;
        if (exp_err != 0)
        begin
            check_flag("op_error", op_error, 1'b1);
            next_cycle();
            check_flag("busy", busy, 1'b0);
        end
        else
        begin
            // Slow feed pushes one line every four cycles.
            if (slow != 0)
            begin
                foreach (sample_lines[i])
                begin
                    repeat (3) next_cycle();
                    push_sample(sample_lines[i]);
                end
            end
            guard = 0;
            while (done_pulses == start_pulses && guard < 2000)
            begin
                next_cycle();
                guard++;
            end
            if (done_pulses == start_pulses)
            begin
                other_errors++;
                $display("Timed out waiting for op_done.");
            end
            repeat (4) next_cycle();
            check_flag("op_done once", done_pulses == start_pulses + 1, 1'b1);
            check_flag("busy", busy, 1'b0);
            foreach (exp_lines[i])
                shadow[offset + i] = exp_lines[i];
            cnt   = 0;
            guard = 0;
            while (!forward_empty && guard < 200)
            begin
                forward_re = 1'b1;
                next_cycle();
                forward_re = 1'b0;
                got = forward_rdata;
                if (cnt < fwd_lines.size())
                    check_line($sformatf("forward[%0d]", cnt), got, fwd_lines[cnt]);
                cnt++;
                guard++;
            end
            check_flag("forward count", cnt == fwd_lines.size(), 1'b1);
        end
        verify_model();
    endtask

    initial
    begin
        string hdr;
        int    code;
        value_errors = 0;
        other_errors = 0;
        done_pulses  = 0;
        reset        = 1'b1;
        op_start     = 1'b0;
        regs         = '0;
        sample_we    = 1'b0;
        sample_wdata = '0;
        gradient_we  = 1'b0;
        gradient_wdata = '0;
        host_we      = 1'b0;
        host_waddr   = '0;
        host_wdata   = '0;
        host_raddr   = '0;
        forward_re   = 1'b0;
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        // Background model tags each lane with its lane and address.
        for (int a = 0; a < glm_regs_pkg::model_depth; a++)
            write_model(a, {4'ha, 2'd3, 4'h0, 6'(a), 4'ha, 2'd2, 4'h0, 6'(a),
                            4'ha, 2'd1, 4'h0, 6'(a), 4'ha, 2'd0, 4'h0, 6'(a)});
        fd = $fopen("dv/glm_update_tests.txt", "r");
        if (fd == 0)
        begin
            other_errors++;
            $display("Could not open the tests file.");
        end
        else
        begin
            code = $fgets(hdr, fd);
            code = $fgets(hdr, fd);
            code = $fscanf(fd, "%d %d %d %d %d %d", offset, length, iters, fwd, slow, exp_err);
            while (code == 6 && other_errors == 0)
            begin
                run_test();
                code = $fscanf(fd, "%d %d %d %d %d %d",
                               offset, length, iters, fwd, slow, exp_err);
            end
            $fclose(fd);
        end
        $display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/glm_update_checker.sv
`timescale 1ns/1ps
`default_nettype none

module glm_update_checker
(
    input wire logic clk,
    input wire logic reset,
    input wire logic op_done,
    input wire logic op_error,
    input wire logic busy,
    input wire logic launch,
    input wire logic sample_we,
    input wire logic sample_full,
    input wire logic sample_re,
    input wire logic sample_empty,
    input wire logic gradient_we,
    input wire logic gradient_full,
    input wire logic gradient_re,
    input wire logic gradient_empty,
    input wire logic forward_we,
    input wire logic forward_full,
    input wire logic forward_re,
    input wire logic forward_empty,
    input wire logic mult_trigger,
    input wire logic mult_valid
);
    a_done_error: assert property (@(posedge clk) disable iff (reset) !(op_done && op_error))
        else $error("op_done and op_error fired together");

    // Busy covers the whole run.
    a_busy_run: assert property (@(posedge clk) disable iff (reset)
        launch |-> (busy until op_done))
        else $error("busy dropped before op_done");

    a_sample_full: assert property (@(posedge clk) disable iff (reset) sample_we |-> !sample_full)
        else $error("write to full samples FIFO");
    a_grad_full: assert property (@(posedge clk) disable iff (reset) gradient_we |-> !gradient_full)
        else $error("write to full gradient FIFO");
    a_fwd_full: assert property (@(posedge clk) disable iff (reset) forward_we |-> !forward_full)
        else $error("write to full forward FIFO");
    a_sample_empty: assert property (@(posedge clk) disable iff (reset) sample_re |-> !sample_empty)
        else $error("read from empty samples FIFO");
    a_grad_empty: assert property (@(posedge clk) disable iff (reset)
        gradient_re |-> !gradient_empty)
        else $error("read from empty gradient FIFO");
    a_fwd_empty: assert property (@(posedge clk) disable iff (reset) forward_re |-> !forward_empty)
        else $error("read from empty forward FIFO");

    // Multiplier latency is fixed at two.
    a_mult_lat: assert property (@(posedge clk) disable iff (reset) mult_trigger |-> ##2 mult_valid)
        else $error("mult_valid missing two cycles after mult_trigger");

endmodule

bind glm_update_top glm_update_checker u_checker
(
    .clk(clk), .reset(reset), .op_done(op_done), .op_error(op_error), .busy(busy),
    .launch(launch), .sample_we(sample_we), .sample_full(sample_full),
    .sample_re(sample_re), .sample_empty(sample_empty), .gradient_we(gradient_we),
    .gradient_full(gradient_full), .gradient_re(gradient_re),
    .gradient_empty(gradient_empty), .forward_we(forward_we), .forward_full(forward_full),
    .forward_re(forward_re), .forward_empty(forward_empty),
    .mult_trigger(mult_trigger), .mult_valid(mult_valid)
);

`default_nettype wire

// File: rtl/glm_update_top.sv
`timescale 1ns/1ps
`default_nettype none

module glm_update_top
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       op_start,
    input  glm_regs_pkg::update_regs_t regs,
    input  logic                       sample_we,
    input  glm_fixed_pkg::line_t       sample_wdata,
    input  logic                       gradient_we,
    input  glm_fixed_pkg::scalar_t     gradient_wdata,
    input  logic                       host_we,
    input  glm_regs_pkg::addr_t        host_waddr,
    input  glm_fixed_pkg::line_t       host_wdata,
    input  glm_regs_pkg::addr_t        host_raddr,
    output glm_fixed_pkg::line_t       host_rdata,
    input  logic                       forward_re,
    output logic                       op_done,
    output logic                       op_error,
    output logic                       busy,
    output logic                       sample_full,
    output logic                       gradient_full,
    output logic                       forward_empty,
    output glm_fixed_pkg::line_t       forward_rdata
);
    logic                       launch;
    logic                       finish;
    glm_regs_pkg::update_regs_t cfg;
    logic                       sample_re;
    logic                       sample_empty;
    glm_fixed_pkg::line_t       sample_rdata;
    logic                       gradient_re;
    logic                       gradient_empty;
    glm_fixed_pkg::scalar_t     gradient_rdata;
    logic                       mult_trigger;
    glm_fixed_pkg::scalar_t     mult_scalar;
    glm_fixed_pkg::line_t       mult_vector;
    logic                       mult_valid;
    glm_fixed_pkg::line_t       mult_result;
    glm_regs_pkg::addr_t        eng_raddr;
    glm_regs_pkg::addr_t        ram_raddr;
    glm_fixed_pkg::line_t       model_rdata;
    logic                       model_we;
    glm_regs_pkg::addr_t        model_waddr;
    glm_fixed_pkg::line_t       model_wdata;
    logic                       forward_we;
    glm_fixed_pkg::line_t       forward_wdata;
    logic                       forward_full;

    // Host reads back the model only between runs.
    assign ram_raddr  = busy ? eng_raddr : host_raddr;
    assign host_rdata = model_rdata;

    update_config u_config
    (
        .clk, .reset, .op_start, .regs, .finish,
        .launch, .cfg, .busy, .op_error, .op_done
    );

    // Sample and forward FIFOs hold a whole run of lines.
    line_fifo #(.payload_t(glm_fixed_pkg::line_t), .depth(64)) u_sample_fifo
    (
        .clk, .reset, .we(sample_we), .wdata(sample_wdata), .re(sample_re),
        .rdata(sample_rdata), .empty(sample_empty), .full(sample_full)
    );

    line_fifo #(.payload_t(glm_fixed_pkg::scalar_t), .depth(16)) u_gradient_fifo
    (
        .clk, .reset, .we(gradient_we), .wdata(gradient_wdata), .re(gradient_re),
        .rdata(gradient_rdata), .empty(gradient_empty), .full(gradient_full)
    );

    line_fifo #(.payload_t(glm_fixed_pkg::line_t), .depth(64)) u_forward_fifo
    (
        .clk, .reset, .we(forward_we), .wdata(forward_wdata), .re(forward_re),
        .rdata(forward_rdata), .empty(forward_empty), .full(forward_full)
    );

    model_ram u_model_ram
    (
        .clk, .busy, .host_we, .host_waddr, .host_wdata,
        .eng_we(model_we), .eng_waddr(model_waddr), .eng_wdata(model_wdata),
        .raddr(ram_raddr), .rdata(model_rdata)
    );

    scalar_vector_mult u_mult
    (
        .clk, .reset, .trigger(mult_trigger), .scalar(mult_scalar), .vector(mult_vector),
        .result_valid(mult_valid), .result(mult_result)
    );

    glm_update u_engine
    (
        .clk, .reset, .launch, .cfg,
        .sample_empty, .sample_rdata, .gradient_empty, .gradient_rdata,
        .mult_valid, .mult_result, .model_rdata,
        .sample_re, .gradient_re, .mult_trigger, .mult_scalar, .mult_vector,
        .model_raddr(eng_raddr), .model_we, .model_waddr, .model_wdata,
        .forward_we, .forward_wdata, .finish
    );

endmodule

`default_nettype wire

// File: rtl/glm_update.sv
`timescale 1ns/1ps
`default_nettype none

module glm_update
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       launch,
    input  glm_regs_pkg::update_regs_t cfg,
    input  logic                       sample_empty,
    input  glm_fixed_pkg::line_t       sample_rdata,
    input  logic                       gradient_empty,
    input  glm_fixed_pkg::scalar_t     gradient_rdata,
    input  logic                       mult_valid,
    input  glm_fixed_pkg::line_t       mult_result,
    input  glm_fixed_pkg::line_t       model_rdata,
    output logic                       sample_re,
    output logic                       gradient_re,
    output logic                       mult_trigger,
    output glm_fixed_pkg::scalar_t     mult_scalar,
    output glm_fixed_pkg::line_t       mult_vector,
    output glm_regs_pkg::addr_t        model_raddr,
    output logic                       model_we,
    output glm_regs_pkg::addr_t        model_waddr,
    output glm_fixed_pkg::line_t       model_wdata,
    output logic                       forward_we,
    output glm_fixed_pkg::line_t       forward_wdata,
    output logic                       finish
);
    typedef enum logic {st_idle, st_running} state_t;

    state_t               state;
    logic [15:0]          req_cnt;
    logic [15:0]          fetch_cnt;
    logic [15:0]          prod_cnt;
    logic [15:0]          write_cnt;
    logic [15:0]          perf_iter;
    logic [15:0]          fin_iter;
    logic                 first_line;
    logic                 last_write;
    logic                 sub_valid;
    glm_fixed_pkg::line_t sub_result;

    // First line of an iteration also pops the gradient.
    always_comb
    begin
        first_line = (req_cnt == '0);
        sample_re  = 1'b0;
        if (state == st_running && !sample_empty)
        begin
            if (first_line)
                sample_re = !gradient_empty;
            else
                sample_re = (req_cnt < cfg.model_length);
        end
        gradient_re = sample_re && first_line;
        last_write  = sub_valid && (write_cnt == cfg.model_length - 16'd1) &&
                      (fin_iter == cfg.num_iterations - 16'd1);
    end

    // Popped gradient holds in the FIFO output register all iteration.
    assign mult_scalar = gradient_rdata;
    assign mult_vector = sample_rdata;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state        <= st_idle;
            mult_trigger <= 1'b0;
            sub_valid    <= 1'b0;
            model_we     <= 1'b0;
            forward_we   <= 1'b0;
            finish       <= 1'b0;
        end
        else
        begin
            mult_trigger <= sample_re;
            sub_valid    <= mult_valid;
            model_we     <= sub_valid;
            forward_we   <= sub_valid && cfg.forward_enable;
            // Finish lines up with the last write enable.
            finish       <= last_write;
            if (state == st_idle && launch)
                state <= st_running;
            else if (last_write)
                state <= st_idle;
        end
    end

    // Line and iteration counters, cleared between runs.
    always_ff @(posedge clk)
    begin
        if (reset || state == st_idle)
        begin
            req_cnt   <= '0;
            fetch_cnt <= '0;
            prod_cnt  <= '0;
            write_cnt <= '0;
            perf_iter <= '0;
            fin_iter  <= '0;
        end
        else
        begin
            if (sample_re)
                req_cnt <= req_cnt + 16'd1;

            if (mult_trigger)
                fetch_cnt <= (fetch_cnt == cfg.model_length - 16'd1) ? '0 : fetch_cnt + 16'd1;

            // Last product back, so the next iteration may start popping.
            if (mult_valid)
            begin
                prod_cnt <= prod_cnt + 16'd1;
                if (prod_cnt == cfg.model_length - 16'd1)
                begin
                    prod_cnt  <= '0;
                    perf_iter <= perf_iter + 16'd1;
                    if (perf_iter != cfg.num_iterations - 16'd1)
                        req_cnt <= '0;
                end
            end

            if (sub_valid)
            begin
                write_cnt <= write_cnt + 16'd1;
                if (write_cnt == cfg.model_length - 16'd1)
                begin
                    write_cnt <= '0;
                    fin_iter  <= fin_iter + 16'd1;
                end
            end
        end
    end

    // Model fetch, lane-wise wrapping subtract and write-back data.
    always_ff @(posedge clk)
    begin
        if (mult_trigger)
            model_raddr <= cfg.model_offset + glm_regs_pkg::addr_t'(fetch_cnt);
        if (mult_valid)
        begin
            for (int i = 0; i < glm_fixed_pkg::lanes_per_line; i++)
                sub_result[i] <= model_rdata[i] - mult_result[i];
        end
        model_wdata <= sub_result;
        model_waddr <= cfg.model_offset + glm_regs_pkg::addr_t'(write_cnt);
    end

    // Forwarded lines are the written lines.
    assign forward_wdata = model_wdata;

endmodule

`default_nettype wire

// File: rtl/scalar_vector_mult.sv
`timescale 1ns/1ps
`default_nettype none

module scalar_vector_mult
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   trigger,
    input  glm_fixed_pkg::scalar_t scalar,
    input  glm_fixed_pkg::line_t   vector,
    output logic                   result_valid,
    output glm_fixed_pkg::line_t   result
);
    logic signed [2*glm_fixed_pkg::lane_bits-1:0] prod [glm_fixed_pkg::lanes_per_line];
    logic [1:0]                                   valid_sr;

    // Valid travels beside the two data stages.
    always_ff @(posedge clk)
    begin
        if (reset)
            valid_sr <= 2'b00;
        else
            valid_sr <= {valid_sr[0], trigger};
    end

    assign result_valid = valid_sr[1];

    // Stage one, full width signed products.
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < glm_fixed_pkg::lanes_per_line; i++)
            prod[i] <= scalar * vector[i];
    end

    // Stage two drops the extra fraction bits and wraps to one lane.
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < glm_fixed_pkg::lanes_per_line; i++)
            result[i] <= glm_fixed_pkg::lane_t'(prod[i] >>> glm_fixed_pkg::frac_bits);
    end

endmodule

`default_nettype wire

// File: rtl/model_ram.sv
`timescale 1ns/1ps
`default_nettype none

module model_ram
(
    input  logic                  clk,
    input  logic                  busy,
    input  logic                  host_we,
    input  glm_regs_pkg::addr_t   host_waddr,
    input  glm_fixed_pkg::line_t  host_wdata,
    input  logic                  eng_we,
    input  glm_regs_pkg::addr_t   eng_waddr,
    input  glm_fixed_pkg::line_t  eng_wdata,
    input  glm_regs_pkg::addr_t   raddr,
    output glm_fixed_pkg::line_t  rdata
);
    glm_fixed_pkg::line_t mem [glm_regs_pkg::model_depth];
    logic                 wr_en;
    glm_regs_pkg::addr_t  wr_addr;
    glm_fixed_pkg::line_t wr_data;

    // Engine owns the write port during a run.
    always_comb
    begin
        wr_en   = busy ? eng_we    : host_we;
        wr_addr = busy ? eng_waddr : host_waddr;
        wr_data = busy ? eng_wdata : host_wdata;
    end

    // Read before write on the same address.
    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

// File: rtl/line_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module line_fifo
#(
    parameter type payload_t = logic [15:0],
    parameter int  depth     = 16
)
(
    input  logic     clk,
    input  logic     reset,
    input  logic     we,
    input  payload_t wdata,
    input  logic     re,
    output payload_t rdata,
    output logic     empty,
    output logic     full
);
    payload_t                 mem [depth];
    logic [$clog2(depth)-1:0] wr_ptr;
    logic [$clog2(depth)-1:0] rd_ptr;
    logic [$clog2(depth):0]   count;
    logic                     do_write;
    logic                     do_read;

    assign empty = (count == '0);
    // Depth is a power of two, so the top count bit means full.
    assign full  = count[$clog2(depth)];

    // Overflowing writes and underflowing reads are dropped.
    assign do_write = we && !full;
    assign do_read  = re && !empty;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_write)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_read)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage and output register.
    always_ff @(posedge clk)
    begin
        if (do_write)
            mem[wr_ptr] <= wdata;
        if (do_read)
            rdata <= mem[rd_ptr];
    end

endmodule

`default_nettype wire

// File: rtl/update_config.sv
`timescale 1ns/1ps
`default_nettype none

module update_config
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       op_start,
    input  glm_regs_pkg::update_regs_t regs,
    input  logic                       finish,
    output logic                       launch,
    output glm_regs_pkg::update_regs_t cfg,
    output logic                       busy,
    output logic                       op_error,
    output logic                       op_done
);
    logic [16:0] range_end;
    logic        regs_bad;
    logic        accept;

    // Widened so the sum cannot wrap.
    always_comb
    begin
        range_end = 17'(regs.model_offset) + 17'(regs.model_length);
        regs_bad  = (regs.model_length == '0) || (regs.num_iterations == '0) ||
                    (range_end > 17'(glm_regs_pkg::model_depth));
        accept    = op_start && !busy && !regs_bad;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            launch   <= 1'b0;
            busy     <= 1'b0;
            op_error <= 1'b0;
            op_done  <= 1'b0;
        end
        else
        begin
            launch   <= accept;
            op_error <= op_start && !busy && regs_bad;
            op_done  <= finish;
            if (finish)
                busy <= 1'b0;
            else if (accept)
                busy <= 1'b1;
        end
    end

    // Instruction stays put for the whole run.
    always_ff @(posedge clk)
    begin
        if (accept)
            cfg <= regs;
    end

endmodule

`default_nettype wire

// File: rtl/glm_regs_pkg.sv
`default_nettype none

package glm_regs_pkg;

    // Model RAM geometry.
    localparam int model_depth = 64;
    localparam int addr_bits   = 6;

    typedef logic [addr_bits-1:0] addr_t;

    // One update instruction.
    typedef struct packed {
        addr_t       model_offset;
        logic [15:0] model_length;
        logic [15:0] num_iterations;
        logic        forward_enable;
    } update_regs_t;

endpackage

`default_nettype wire

// File: rtl/glm_fixed_pkg.sv
`default_nettype none

package glm_fixed_pkg;

    // Line geometry.
    localparam int lanes_per_line = 4;
    localparam int lane_bits      = 16;

    // Signed Q8.8 values.
    localparam int frac_bits = 8;

    typedef logic signed [lane_bits-1:0] lane_t;

    // Lane 0 sits in the low bits.
    typedef lane_t [lanes_per_line-1:0] line_t;

    // Gradient shares the lane format.
    typedef logic signed [lane_bits-1:0] scalar_t;

endpackage

`default_nettype wire
